// File: tb.f
+incdir+include
source/spmv_types_pkg.sv
source/spmv_ctrl_pkg.sv
source/spmv_decode.sv
source/spmv_weight_ram.sv
source/spmv_execute.sv
source/spmv_result.sv
source/spmv_top.sv
verif/spmv_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= spmv_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/spmv_tb.sv
`include "spmv_defines.svh"

module spmv_tb;
  import spmv_types_pkg::*;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 8;
  localparam logic [31:0] RAND_SEED = 32'h1309a785;

  // entries issued by each directed test with the random rows at their longest
  localparam int SMALL_ROWS   = 6;
  localparam int BP_ROWS      = 8;
  localparam int RAND_ROWS    = 40;
  localparam int MAX_ENTRIES  = 1 + SMALL_ROWS * 3 + 2 * 4 + BP_ROWS * 2 + RAND_ROWS * 8;
  localparam int TIMEOUT_CYCLES =
    200 * MAX_ENTRIES + 1000 + `SPMV_WT_DEPTH + RESET_CYCLES;

  // output ready modes
  localparam int READY_ON   = 0;
  localparam int READY_OFF  = 1;
  localparam int READY_RAND = 2;

  logic  clk = 1'b0;
  logic  rst_n;
  logic  in_valid_i;
  col_t  in_col_i;
  data_t in_value_i;
  logic  in_last_i;
  logic  in_ready_o;
  logic  wt_we_i;
  col_t  wt_addr_i;
  data_t wt_data_i;
  logic  out_valid_o;
  data_t out_sum_o;
  logic  out_sat_o;
  row_t  out_row_o;
  logic  out_ready_i;

  // reference model state
  data_t wt_model [`SPMV_WT_DEPTH];
  data_t exp_sum_q [$];
  logic  exp_sat_q [$];
  row_t  exp_row_q [$];
  row_t  next_row;

  // row under construction
  col_t  row_col [8];
  data_t row_val [8];

  int    ready_mode;
  logic  stall_seen;
  logic  bp_send_done;

  spmv_top i_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (in_valid_i),
    .in_col_i    (in_col_i),
    .in_value_i  (in_value_i),
    .in_last_i   (in_last_i),
    .in_ready_o  (in_ready_o),
    .wt_we_i     (wt_we_i),
    .wt_addr_i   (wt_addr_i),
    .wt_data_i   (wt_data_i),
    .out_valid_o (out_valid_o),
    .out_sum_o   (out_sum_o),
    .out_sat_o   (out_sat_o),
    .out_row_o   (out_row_o),
    .out_ready_i (out_ready_i)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic abort_run();
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("** Error: %s expected 0x%0h, got 0x%0h", name, expected, actual);
      abort_run();
    end
  endtask

  task automatic write_weight(input col_t addr, input data_t value);
    @(negedge clk);
    wt_we_i   = 1'b1;
    wt_addr_i = addr;
    wt_data_i = value;
    wt_model[addr] = value;
    @(posedge clk);
  endtask

  task automatic end_weight_writes();
    @(negedge clk);
    wt_we_i = 1'b0;
  endtask

  task automatic load_weights();
    int a;
    for (a = 0; a < `SPMV_WT_DEPTH; a++) begin
      write_weight(col_t'(a), data_t'($urandom));
    end
    end_weight_writes();
  endtask

  // holds the entry until it transfers and returns right after the accepting edge
  task automatic send_entry(input col_t col, input data_t value, input logic last);
    @(negedge clk);
    in_valid_i = 1'b1;
    in_col_i   = col;
    in_value_i = value;
    in_last_i  = last;
    while (in_ready_o !== 1'b1) begin
      stall_seen = 1'b1;
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  task automatic idle_input();
    @(negedge clk);
    in_valid_i = 1'b0;
    in_last_i  = 1'b0;
  endtask

  // exact dot product clamped to +/-127
  task automatic send_row(input int len);
    int    i;
    int    acc;
    data_t sum;
    logic  sat;
    acc = 0;
    for (i = 0; i < len; i++) begin
      acc += int'(row_val[i]) * int'(wt_model[row_col[i]]);
    end
    if (acc > `SPMV_SAT_MAX) begin
      sum = data_t'(`SPMV_SAT_MAX);
      sat = 1'b1;
    end else if (acc < -`SPMV_SAT_MAX) begin
      sum = data_t'(-`SPMV_SAT_MAX);
      sat = 1'b1;
    end else begin
      sum = data_t'(acc);
      sat = 1'b0;
    end
    exp_sum_q.push_back(sum);
    exp_sat_q.push_back(sat);
    exp_row_q.push_back(next_row);
    next_row = next_row + 1'b1;
    for (i = 0; i < len; i++) begin
      send_entry(row_col[i], row_val[i], i == len - 1);
    end
  endtask

  task automatic wait_drain();
    while (exp_sum_q.size() != 0) begin
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  task automatic check_reset_state();
    check_eq("out_valid_o", 0, out_valid_o);
    check_eq("in_ready_o", 1, in_ready_o);
  endtask

  task automatic single_entry_latency();
    int edges;
    write_weight(col_t'(5), data_t'(9));
    end_weight_writes();
    row_col[0] = col_t'(5);
    row_val[0] = data_t'(-7);
    send_row(1);
    idle_input();
    edges = 0;
    while (out_valid_o !== 1'b1 && edges < 8) begin
      @(posedge clk);
      edges++;
      @(negedge clk);
    end
    check_eq("out_valid_o rise edge count", 3, edges);
    wait_drain();
  endtask

  task automatic small_row_sums();
    int r;
    int i;
    for (i = 0; i < SMALL_ROWS * 3; i++) begin
      write_weight(col_t'(200 + i), data_t'(int'($urandom_range(8, 0)) - 4));
    end
    end_weight_writes();
    for (r = 0; r < SMALL_ROWS; r++) begin
      for (i = 0; i < 3; i++) begin
        row_col[i] = col_t'(200 + r * 3 + i);
        row_val[i] = data_t'(int'($urandom_range(8, 0)) - 4);
      end
      send_row(3);
    end
    idle_input();
    wait_drain();
  endtask

  task automatic saturating_rows();
    int i;
    for (i = 0; i < 4; i++) begin
      write_weight(col_t'(100 + i), data_t'(120));
    end
    end_weight_writes();
    for (i = 0; i < 4; i++) begin
      row_col[i] = col_t'(100 + i);
      row_val[i] = data_t'(90 + 10 * i);
    end
    send_row(4);
    for (i = 0; i < 4; i++) begin
      row_val[i] = data_t'(-90 - 10 * i);
    end
    send_row(4);
    idle_input();
    wait_drain();
  endtask

  task automatic held_output_backpressure();
    int r;
    ready_mode   = READY_OFF;
    stall_seen   = 1'b0;
    bp_send_done = 1'b0;
    fork
      begin
        for (r = 0; r < BP_ROWS; r++) begin
          row_col[0] = col_t'($urandom_range(`SPMV_WT_DEPTH - 1, 0));
          row_col[1] = col_t'($urandom_range(`SPMV_WT_DEPTH - 1, 0));
          row_val[0] = data_t'($urandom);
          row_val[1] = data_t'($urandom);
          send_row(2);
        end
        idle_input();
        bp_send_done = 1'b1;
      end
      begin
        while (!stall_seen && !bp_send_done) begin
          @(negedge clk);
        end
        assert (stall_seen) else begin
          $display("in_ready_o never dropped while the output was held");
          abort_run();
        end
        // keep the queue full for a while before releasing it
        repeat (50) @(negedge clk);
        ready_mode = READY_ON;
      end
    join
    wait_drain();
  endtask

  task automatic random_row_stream();
    int r;
    int i;
    int len;
    ready_mode = READY_RAND;
    for (r = 0; r < RAND_ROWS; r++) begin
      len = int'($urandom_range(8, 1));
      for (i = 0; i < len; i++) begin
        row_col[i] = col_t'($urandom_range(`SPMV_WT_DEPTH - 1, 0));
        row_val[i] = data_t'($urandom);
      end
      send_row(len);
    end
    idle_input();
    wait_drain();
    ready_mode = READY_ON;
  endtask

  // drives out_ready_i and checks every result that will transfer on the next edge
  initial begin : output_monitor
    out_ready_i = 1'b0;
    forever begin
      @(negedge clk);
      case (ready_mode)
        READY_ON:  out_ready_i = 1'b1;
        READY_OFF: out_ready_i = 1'b0;
        default:   out_ready_i = 1'($urandom_range(1, 0));
      endcase
      if (rst_n && out_valid_o && out_ready_i) begin
        assert (exp_sum_q.size() != 0) else begin
          $display("a result was delivered with no row outstanding");
          abort_run();
        end
        check_eq("out_row_o", 32'(exp_row_q[0]), 32'(out_row_o));
        check_eq("out_sum_o", 32'(exp_sum_q[0]), 32'(out_sum_o));
        check_eq("out_sat_o", 32'(exp_sat_q[0]), 32'(out_sat_o));
        void'(exp_sum_q.pop_front());
        void'(exp_sat_q.pop_front());
        void'(exp_row_q.pop_front());
      end
    end
  end

  initial begin : watchdog
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("watchdog expired, the DUT stopped delivering results");
    abort_run();
  end

  initial begin : main_sequence
    void'($urandom(RAND_SEED));
    rst_n         = 1'b0;
    in_valid_i    = 1'b0;
    in_col_i      = '0;
    in_value_i    = '0;
    in_last_i     = 1'b0;
    wt_we_i       = 1'b0;
    wt_addr_i     = '0;
    wt_data_i     = '0;
    ready_mode    = READY_ON;
    stall_seen    = 1'b0;
    bp_send_done  = 1'b0;
    next_row      = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    check_reset_state();
    load_weights();
    single_entry_latency();
    small_row_sums();
    saturating_rows();
    held_output_backpressure();
    random_row_stream();

    // a duplicated row would still reach the output monitor in this window
    repeat (8) @(negedge clk);
    $display("Verification passed");
    $finish;
  end

endmodule

// File: source/spmv_top.sv
module spmv_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  in_valid_i,
  input  spmv_types_pkg::col_t  in_col_i,
  input  spmv_types_pkg::data_t in_value_i,
  input  logic                  in_last_i,
  output logic                  in_ready_o,
  input  logic                  wt_we_i,
  input  spmv_types_pkg::col_t  wt_addr_i,
  input  spmv_types_pkg::data_t wt_data_i,
  output logic                  out_valid_o,
  output spmv_types_pkg::data_t out_sum_o,
  output logic                  out_sat_o,
  output spmv_types_pkg::row_t  out_row_o,
  input  logic                  out_ready_i
);
  import spmv_types_pkg::*;

  logic  advance;
  col_t  rd_addr;

  // decode to execute
  logic  dec_valid;
  data_t dec_value;
  logic  dec_first;
  logic  dec_last;
  row_t  dec_row;

  // execute to result
  logic  sum_valid;
  acc_t  sum_acc;
  row_t  sum_row;

  spmv_decode i_decode (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (in_valid_i),
    .in_col_i    (in_col_i),
    .in_value_i  (in_value_i),
    .in_last_i   (in_last_i),
    .in_ready_o  (in_ready_o),
    .advance_i   (advance),
    .rd_addr_o   (rd_addr),
    .dec_valid_o (dec_valid),
    .dec_value_o (dec_value),
    .dec_first_o (dec_first),
    .dec_last_o  (dec_last),
    .dec_row_o   (dec_row)
  );

  spmv_execute i_execute (
    .clk         (clk),
    .rst_n       (rst_n),
    .advance_i   (advance),
    .rd_addr_i   (rd_addr),
    .wt_we_i     (wt_we_i),
    .wt_addr_i   (wt_addr_i),
    .wt_data_i   (wt_data_i),
    .dec_valid_i (dec_valid),
    .dec_value_i (dec_value),
    .dec_first_i (dec_first),
    .dec_last_i  (dec_last),
    .dec_row_i   (dec_row),
    .sum_valid_o (sum_valid),
    .sum_acc_o   (sum_acc),
    .sum_row_o   (sum_row)
  );

  spmv_result i_result (
    .clk         (clk),
    .rst_n       (rst_n),
    .sum_valid_i (sum_valid),
    .sum_acc_i   (sum_acc),
    .sum_row_i   (sum_row),
    .advance_o   (advance),
    .out_valid_o (out_valid_o),
    .out_sum_o   (out_sum_o),
    .out_sat_o   (out_sat_o),
    .out_row_o   (out_row_o),
    .out_ready_i (out_ready_i)
  );

endmodule

// File: source/spmv_result.sv
`include "spmv_defines.svh"

module spmv_result (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  sum_valid_i,
  input  spmv_types_pkg::acc_t  sum_acc_i,
  input  spmv_types_pkg::row_t  sum_row_i,
  output logic                  advance_o,
  output logic                  out_valid_o,
  output spmv_types_pkg::data_t out_sum_o,
  output logic                  out_sat_o,
  output spmv_types_pkg::row_t  out_row_o,
  input  logic                  out_ready_i
);
  import spmv_types_pkg::*;

  localparam int DEPTH = `SPMV_QUEUE_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  data_t q_sum [DEPTH];
  logic  q_sat [DEPTH];
  row_t  q_row [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  data_t clamped;
  logic  sat;
  logic  push;
  logic  pop;

  // clamp to the symmetric 8-bit range
  always_comb begin
    sat     = 1'b1;
    clamped = data_t'(`SPMV_SAT_MAX);
    if (sum_acc_i < -acc_t'(`SPMV_SAT_MAX)) begin
      clamped = -data_t'(`SPMV_SAT_MAX);
    end else if (sum_acc_i <= acc_t'(`SPMV_SAT_MAX)) begin
      sat     = 1'b0;
      clamped = sum_acc_i[`SPMV_DATA_W-1:0];
    end
  end

  // stall the pipeline as soon as the queue is full
  assign advance_o   = (count_q != CNT_W'(DEPTH));
  assign out_valid_o = (count_q != '0);
  assign push        = sum_valid_i & advance_o;
  assign pop         = out_valid_o & out_ready_i;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      q_sum[wr_ptr_q] <= clamped;
      q_sat[wr_ptr_q] <= sat;
      q_row[wr_ptr_q] <= sum_row_i;
    end
  end

  assign out_sum_o = q_sum[rd_ptr_q];
  assign out_sat_o = q_sat[rd_ptr_q];
  assign out_row_o = q_row[rd_ptr_q];

  // a row that meets a full queue must stay presented until it can be pushed
  a_full_holds_row : assert property (
    @(posedge clk) disable iff (!rst_n)
    (sum_valid_i && !advance_o) |=> (sum_valid_i && $stable(sum_row_i) && $stable(sum_acc_i))
  );

endmodule

// File: source/spmv_execute.sv
module spmv_execute (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  advance_i,
  input  spmv_types_pkg::col_t  rd_addr_i,
  input  logic                  wt_we_i,
  input  spmv_types_pkg::col_t  wt_addr_i,
  input  spmv_types_pkg::data_t wt_data_i,
  input  logic                  dec_valid_i,
  input  spmv_types_pkg::data_t dec_value_i,
  input  logic                  dec_first_i,
  input  logic                  dec_last_i,
  input  spmv_types_pkg::row_t  dec_row_i,
  output logic                  sum_valid_o,
  output spmv_types_pkg::acc_t  sum_acc_o,
  output spmv_types_pkg::row_t  sum_row_o
);
  import spmv_types_pkg::*;

  data_t wt_rd_data;

  // multiply stage
  logic  prod_valid_q;
  logic  prod_first_q;
  logic  prod_last_q;
  row_t  prod_row_q;
  prod_t prod_q;

  // accumulate stage
  acc_t  acc_q;
  logic  row_open_q;

  spmv_weight_ram i_weight_ram (
    .clk       (clk),
    .we_i      (wt_we_i),
    .wr_addr_i (wt_addr_i),
    .wr_data_i (wt_data_i),
    .rd_en_i   (advance_i),
    .rd_addr_i (rd_addr_i),
    .rd_data_o (wt_rd_data)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      prod_valid_q <= 1'b0;
      sum_valid_o  <= 1'b0;
      row_open_q   <= 1'b0;
    end else if (advance_i) begin
      prod_valid_q <= dec_valid_i;
      // finished row is shown for one cycle
      sum_valid_o  <= prod_valid_q & prod_last_q;
      if (dec_valid_i) begin
        row_open_q <= ~dec_last_i;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (advance_i) begin
      if (dec_valid_i) begin
        prod_q       <= dec_value_i * wt_rd_data;
        prod_first_q <= dec_first_i;
        prod_last_q  <= dec_last_i;
        prod_row_q   <= dec_row_i;
      end
      if (prod_valid_q) begin
        // restart on the first entry of a row
        acc_q <= prod_first_q ? acc_t'(prod_q) : acc_q + prod_q;
        if (prod_last_q) begin
          sum_row_o <= prod_row_q;
        end
      end
    end
  end

  assign sum_acc_o = acc_q;

  // decode must close every row before opening the next one
  a_no_nested_row : assert property (
    @(posedge clk) disable iff (!rst_n)
    (advance_i && dec_valid_i && dec_first_i) |-> !row_open_q
  );

endmodule

// File: source/spmv_weight_ram.sv
`include "spmv_defines.svh"

module spmv_weight_ram (
  input  logic                  clk,
  input  logic                  we_i,
  input  spmv_types_pkg::col_t  wr_addr_i,
  input  spmv_types_pkg::data_t wr_data_i,
  input  logic                  rd_en_i,
  input  spmv_types_pkg::col_t  rd_addr_i,
  output spmv_types_pkg::data_t rd_data_o
);
  import spmv_types_pkg::*;

  data_t mem [`SPMV_WT_DEPTH];

  // single write port, loaded while the engine is idle
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
  end

  // registered read, output holds while disabled
  always_ff @(posedge clk) begin
    if (rd_en_i) begin
      rd_data_o <= mem[rd_addr_i];
    end
  end

endmodule

// File: source/spmv_decode.sv
module spmv_decode (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 in_valid_i,
  input  spmv_types_pkg::col_t in_col_i,
  input  spmv_types_pkg::data_t in_value_i,
  input  logic                 in_last_i,
  output logic                 in_ready_o,
  input  logic                 advance_i,
  output spmv_types_pkg::col_t rd_addr_o,
  output logic                 dec_valid_o,
  output spmv_types_pkg::data_t dec_value_o,
  output logic                 dec_first_o,
  output logic                 dec_last_o,
  output spmv_types_pkg::row_t dec_row_o
);
  import spmv_types_pkg::*;
  import spmv_ctrl_pkg::*;

  dec_state_t state_q;
  row_t       row_cnt_q;
  logic       accept;

  // whole pipeline moves together, so input ready is just advance
  assign in_ready_o = advance_i;
  assign accept     = in_valid_i & advance_i;

  // weight read is launched on the accept edge
  assign rd_addr_o = in_col_i;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q     <= DEC_ROW_START;
      row_cnt_q   <= '0;
      dec_valid_o <= 1'b0;
    end else if (advance_i) begin
      dec_valid_o <= in_valid_i;
      if (in_valid_i) begin
        if (in_last_i) begin
          state_q   <= DEC_ROW_START;
          row_cnt_q <= row_cnt_q + 1'b1;
        end else begin
          state_q <= DEC_IN_ROW;
        end
      end
    end
  end

  // entry payload
  always_ff @(posedge clk) begin
    if (accept) begin
      dec_value_o <= in_value_i;
      dec_first_o <= (state_q == DEC_ROW_START);
      dec_last_o  <= in_last_i;
      dec_row_o   <= row_cnt_q;
    end
  end

  // source must hold the column while stalled
  a_col_stable : assert property (
    @(posedge clk) disable iff (!rst_n)
    (in_valid_i && !in_ready_o) |=> $stable(in_col_i)
  );

endmodule

// File: source/spmv_ctrl_pkg.sv
package spmv_ctrl_pkg;

  // decode tracks whether the next entry opens a row
  typedef enum logic [0:0] {
    DEC_ROW_START = 1'b0,
    DEC_IN_ROW    = 1'b1
  } dec_state_t;

endpackage

// File: source/spmv_types_pkg.sv
`include "spmv_defines.svh"

package spmv_types_pkg;

  // one signed data word, used for entry values and weights
  typedef logic signed [`SPMV_DATA_W-1:0] data_t;

  // value times weight
  typedef logic signed [`SPMV_PROD_W-1:0] prod_t;

  // per-row running sum
  typedef logic signed [`SPMV_ACC_W-1:0] acc_t;

  // weight address
  typedef logic [`SPMV_COL_W-1:0] col_t;

  // row number
  typedef logic [`SPMV_ROW_W-1:0] row_t;

endpackage

// File: include/spmv_defines.svh
`ifndef SPMV_DEFINES_SVH
`define SPMV_DEFINES_SVH

// entry value and weight width
`define SPMV_DATA_W 8

// full product of two data words
`define SPMV_PROD_W 16

// row accumulator, wide enough for long rows
`define SPMV_ACC_W 24

// column index into the weight memory
`define SPMV_COL_W 11
`define SPMV_WT_DEPTH 2048

// row number carried with each result
`define SPMV_ROW_W 16

// output queue entries
`define SPMV_QUEUE_DEPTH 4

// symmetric clamp bound, lower bound is the negative
`define SPMV_SAT_MAX 127

`endif
